// ==== include/decode_cfg.svh ====
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

// instruction word
`define DEC_WORD_W 32

// field widths of the three formats
`define DEC_OP_W 6
`define DEC_FUNCT_W 6
`define DEC_REG_W 5
`define DEC_IMM_W 16

`endif

// ==== hw/isa_pkg.sv ====
`include "decode_cfg.svh"

package isa_pkg;

	// primary opcodes still decoded
	typedef enum logic [`DEC_OP_W-1:0] {
		R_TYPE = 6'b000000,
		REGIMM = 6'b000001,
		J      = 6'b000010,
		JAL    = 6'b000011,
		BEQ    = 6'b000100,
		BNE    = 6'b000101,
		BLEZ   = 6'b000110,
		BGTZ   = 6'b000111,
		ADDI   = 6'b001000,
		ADDIU  = 6'b001001,
		SLTI   = 6'b001010,
		SLTIU  = 6'b001011,
		ANDI   = 6'b001100,
		ORI    = 6'b001101,
		XORI   = 6'b001110,
		LUI    = 6'b001111,
		COP0   = 6'b010000,
		LB     = 6'b100000,
		LH     = 6'b100001,
		LW     = 6'b100011,
		LBU    = 6'b100100,
		LHU    = 6'b100101,
		SB     = 6'b101000,
		SH     = 6'b101001,
		SW     = 6'b101011
	} opcode_e;

	typedef enum logic [`DEC_FUNCT_W-1:0] {
		SLL     = 6'b000000,
		SRL     = 6'b000010,
		SRA     = 6'b000011,
		SLLV    = 6'b000100,
		SRLV    = 6'b000110,
		SRAV    = 6'b000111,
		JR      = 6'b001000,
		JALR    = 6'b001001,
		SYSCALL = 6'b001100,
		BREAK   = 6'b001101,
		MFHI    = 6'b010000,
		MTHI    = 6'b010001,
		MFLO    = 6'b010010,
		MTLO    = 6'b010011,
		ADD     = 6'b100000,
		ADDU    = 6'b100001,
		SUB     = 6'b100010,
		SUBU    = 6'b100011,
		AND     = 6'b100100,
		OR      = 6'b100101,
		XOR     = 6'b100110,
		NOR     = 6'b100111,
		SLT     = 6'b101010,
		SLTU    = 6'b101011
	} funct_e;

	// rt field of REGIMM branches
	typedef enum logic [`DEC_REG_W-1:0] {
		BLTZ   = 5'b00000,
		BGEZ   = 5'b00001,
		BLTZAL = 5'b10000,
		BGEZAL = 5'b10001
	} regimm_e;

	// rs field of COP0, ERET is the CO bit with funct 6'h18 and zero fields
	typedef enum logic [`DEC_REG_W-1:0] {
		MFC0 = 5'b00000,
		MTC0 = 5'b00100,
		ERET = 5'b10000
	} cop0_e;

	typedef struct packed {
		opcode_e               op;
		logic [`DEC_REG_W-1:0] rs;
		logic [`DEC_REG_W-1:0] rt;
		logic [`DEC_REG_W-1:0] rd;
		logic [`DEC_REG_W-1:0] shamt;
		funct_e                funct;
	} r_fmt_t;

	typedef struct packed {
		opcode_e               op;
		logic [`DEC_REG_W-1:0] rs;
		logic [`DEC_REG_W-1:0] rt;
		logic [`DEC_IMM_W-1:0] imm;
	} i_fmt_t;

	typedef struct packed {
		opcode_e                          op;
		logic [`DEC_WORD_W-`DEC_OP_W-1:0] target;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		j_fmt_t j;
	} instr_u;

endpackage

// ==== hw/ctrl_pkg.sv ====
package ctrl_pkg;

	// operation class handed from the main decoder to the ALU decoder
	typedef enum logic [3:0] {
		R_TYPE_OP,
		ADDI_OP,
		ADDIU_OP,
		SLTI_OP,
		SLTIU_OP,
		ANDI_OP,
		ORI_OP,
		XORI_OP,
		LUI_OP,
		MEM_OP,
		MTC0_OP,
		MFC0_OP,
		USELESS_OP
	} alu_op_e;

	typedef enum logic [4:0] {
		NOP,
		ADD,
		ADDU,
		SUB,
		SUBU,
		SLT,
		SLTU,
		AND,
		OR,
		XOR,
		NOR,
		LUI,
		SLL,
		SRL,
		SRA,
		SLLV,
		SRLV,
		SRAV,
		MFC0,
		MTC0
	} alu_ctrl_e;

	typedef enum logic [2:0] {
		NONE = 3'd0,
		EQ   = 3'd1,
		NE   = 3'd2,
		LEZ  = 3'd3,
		GTZ  = 3'd4,
		LTZ  = 3'd5,
		GEZ  = 3'd6
	} branch_cond_e;

endpackage

// ==== hw/main_ctrl_dec.sv ====
`timescale 1ns/1ps

module main_ctrl_dec (
	input  isa_pkg::instr_u   instr,
	output logic              regwrite,
	output logic              regdst,
	output logic              is_imm,
	output logic              memtoreg,
	output logic              mem_read,
	output logic              mem_write,
	output logic              sign_ex,
	output ctrl_pkg::alu_op_e alu_op,
	output logic              cp0_write,
	output logic              cp0_read,
	output logic              is_mfc,
	output logic              hilo_read,
	output logic              mfhi,
	output logic              mflo,
	output logic              eret,
	output logic              brk,
	output logic              syscall,
	output logic              ri,
	output logic              only_one_inst
);

	logic is_r;
	logic is_cop0;
	logic eret_word;
	ctrl_pkg::alu_op_e imm_op;

	assign is_r = (instr.r.op == isa_pkg::R_TYPE);
	assign is_cop0 = (instr.r.op == isa_pkg::COP0);

	// all fields below rs must match exactly
	assign eret_word = (instr.r.rs == isa_pkg::ERET) && (instr.r.rt == '0) &&
		(instr.r.rd == '0) && (instr.r.shamt == '0) && (instr.r.funct == 6'h18);

	// zero extend for the logical immediates and lui
	assign sign_ex = !(instr.r.op inside {isa_pkg::ANDI, isa_pkg::ORI, isa_pkg::XORI,
		isa_pkg::LUI});

	assign mfhi = is_r && (instr.r.funct == isa_pkg::MFHI);
	assign mflo = is_r && (instr.r.funct == isa_pkg::MFLO);
	assign hilo_read = mfhi | mflo;
	assign brk = is_r && (instr.r.funct == isa_pkg::BREAK);
	assign syscall = is_r && (instr.r.funct == isa_pkg::SYSCALL);
	assign cp0_write = is_cop0 && (instr.r.rs == isa_pkg::MTC0);
	assign cp0_read = is_cop0 && (instr.r.rs == isa_pkg::MFC0);
	assign eret = is_cop0 && eret_word;

	always_comb begin
		case (instr.i.op)
			isa_pkg::ADDI: imm_op = ctrl_pkg::ADDI_OP;
			isa_pkg::ADDIU: imm_op = ctrl_pkg::ADDIU_OP;
			isa_pkg::SLTI: imm_op = ctrl_pkg::SLTI_OP;
			isa_pkg::SLTIU: imm_op = ctrl_pkg::SLTIU_OP;
			isa_pkg::ANDI: imm_op = ctrl_pkg::ANDI_OP;
			isa_pkg::ORI: imm_op = ctrl_pkg::ORI_OP;
			isa_pkg::XORI: imm_op = ctrl_pkg::XORI_OP;
			isa_pkg::LUI: imm_op = ctrl_pkg::LUI_OP;
			default: imm_op = ctrl_pkg::USELESS_OP;
		endcase
	end

	always_comb begin
		regwrite = 1'b0;
		regdst = 1'b0;
		is_imm = 1'b0;
		memtoreg = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		alu_op = ctrl_pkg::USELESS_OP;
		is_mfc = 1'b0;
		ri = 1'b0;
		only_one_inst = 1'b0;
		case (instr.r.op)
			isa_pkg::R_TYPE: begin
				case (instr.r.funct)
					isa_pkg::ADD, isa_pkg::ADDU, isa_pkg::SUB, isa_pkg::SUBU,
					isa_pkg::SLT, isa_pkg::SLTU, isa_pkg::AND, isa_pkg::OR,
					isa_pkg::XOR, isa_pkg::NOR, isa_pkg::SLL, isa_pkg::SRL,
					isa_pkg::SRA, isa_pkg::SLLV, isa_pkg::SRLV, isa_pkg::SRAV,
					isa_pkg::MFHI, isa_pkg::MFLO, isa_pkg::JALR: begin
						alu_op = ctrl_pkg::R_TYPE_OP;
						regwrite = 1'b1;
						regdst = 1'b1;
					end
					isa_pkg::JR, isa_pkg::MTHI, isa_pkg::MTLO,
					isa_pkg::SYSCALL, isa_pkg::BREAK: begin
						alu_op = ctrl_pkg::R_TYPE_OP;
					end
					default: begin
						ri = 1'b1;
						regwrite = 1'b1;
					end
				endcase
			end
			isa_pkg::ADDI, isa_pkg::ADDIU, isa_pkg::SLTI, isa_pkg::SLTIU,
			isa_pkg::ANDI, isa_pkg::ORI, isa_pkg::XORI, isa_pkg::LUI: begin
				alu_op = imm_op;
				regwrite = 1'b1;
				is_imm = 1'b1;
			end
			isa_pkg::LB, isa_pkg::LBU, isa_pkg::LH, isa_pkg::LHU, isa_pkg::LW: begin
				alu_op = ctrl_pkg::MEM_OP;
				regwrite = 1'b1;
				is_imm = 1'b1;
				memtoreg = 1'b1;
				mem_read = 1'b1;
				only_one_inst = 1'b1;
			end
			isa_pkg::SB, isa_pkg::SH, isa_pkg::SW: begin
				alu_op = ctrl_pkg::MEM_OP;
				is_imm = 1'b1;
				mem_write = 1'b1;
				only_one_inst = 1'b1;
			end
			isa_pkg::BEQ, isa_pkg::BNE, isa_pkg::BLEZ, isa_pkg::BGTZ, isa_pkg::J: ;
			// link to r31
			isa_pkg::JAL: begin
				regwrite = 1'b1;
				regdst = 1'b1;
			end
			isa_pkg::REGIMM: begin
				case (instr.i.rt)
					isa_pkg::BLTZAL, isa_pkg::BGEZAL: begin
						regwrite = 1'b1;
						regdst = 1'b1;
					end
					isa_pkg::BLTZ, isa_pkg::BGEZ: ;
					default: ri = 1'b1;
				endcase
			end
			isa_pkg::COP0: begin
				only_one_inst = 1'b1;
				case (instr.r.rs)
					isa_pkg::MTC0: alu_op = ctrl_pkg::MTC0_OP;
					isa_pkg::MFC0: begin
						alu_op = ctrl_pkg::MFC0_OP;
						regwrite = 1'b1;
						is_imm = 1'b1;
						is_mfc = 1'b1;
					end
					default: ri = !eret_word;
				endcase
			end
			default: ri = 1'b1;
		endcase
	end

endmodule

// ==== hw/alu_ctrl_dec.sv ====
`timescale 1ns/1ps

module alu_ctrl_dec (
	input  ctrl_pkg::alu_op_e   alu_op,
	input  isa_pkg::instr_u     instr,
	output ctrl_pkg::alu_ctrl_e alu_ctrl
);

	ctrl_pkg::alu_ctrl_e funct_ctrl;

	// jumps, hi/lo moves and system calls fall to nop
	always_comb begin
		case (instr.r.funct)
			isa_pkg::ADD: funct_ctrl = ctrl_pkg::ADD;
			isa_pkg::ADDU: funct_ctrl = ctrl_pkg::ADDU;
			isa_pkg::SUB: funct_ctrl = ctrl_pkg::SUB;
			isa_pkg::SUBU: funct_ctrl = ctrl_pkg::SUBU;
			isa_pkg::SLT: funct_ctrl = ctrl_pkg::SLT;
			isa_pkg::SLTU: funct_ctrl = ctrl_pkg::SLTU;
			isa_pkg::AND: funct_ctrl = ctrl_pkg::AND;
			isa_pkg::OR: funct_ctrl = ctrl_pkg::OR;
			isa_pkg::XOR: funct_ctrl = ctrl_pkg::XOR;
			isa_pkg::NOR: funct_ctrl = ctrl_pkg::NOR;
			isa_pkg::SLL: funct_ctrl = ctrl_pkg::SLL;
			isa_pkg::SRL: funct_ctrl = ctrl_pkg::SRL;
			isa_pkg::SRA: funct_ctrl = ctrl_pkg::SRA;
			isa_pkg::SLLV: funct_ctrl = ctrl_pkg::SLLV;
			isa_pkg::SRLV: funct_ctrl = ctrl_pkg::SRLV;
			isa_pkg::SRAV: funct_ctrl = ctrl_pkg::SRAV;
			default: funct_ctrl = ctrl_pkg::NOP;
		endcase
	end

	always_comb begin
		case (alu_op)
			ctrl_pkg::R_TYPE_OP: alu_ctrl = funct_ctrl;
			ctrl_pkg::ADDI_OP: alu_ctrl = ctrl_pkg::ADD;
			ctrl_pkg::ADDIU_OP: alu_ctrl = ctrl_pkg::ADDU;
			ctrl_pkg::SLTI_OP: alu_ctrl = ctrl_pkg::SLT;
			ctrl_pkg::SLTIU_OP: alu_ctrl = ctrl_pkg::SLTU;
			ctrl_pkg::ANDI_OP: alu_ctrl = ctrl_pkg::AND;
			ctrl_pkg::ORI_OP: alu_ctrl = ctrl_pkg::OR;
			ctrl_pkg::XORI_OP: alu_ctrl = ctrl_pkg::XOR;
			ctrl_pkg::LUI_OP: alu_ctrl = ctrl_pkg::LUI;
			// address = base + offset
			ctrl_pkg::MEM_OP: alu_ctrl = ctrl_pkg::ADDU;
			ctrl_pkg::MTC0_OP: alu_ctrl = ctrl_pkg::MTC0;
			ctrl_pkg::MFC0_OP: alu_ctrl = ctrl_pkg::MFC0;
			default: alu_ctrl = ctrl_pkg::NOP;
		endcase
	end

endmodule

// ==== hw/operand_use_dec.sv ====
`timescale 1ns/1ps

module operand_use_dec (
	input  isa_pkg::instr_u instr,
	output logic            read_rs,
	output logic            read_rt
);

	always_comb begin
		read_rs = 1'b0;
		read_rt = 1'b0;
		case (instr.r.op)
			isa_pkg::R_TYPE: begin
				case (instr.r.funct)
					isa_pkg::ADD, isa_pkg::ADDU, isa_pkg::SUB, isa_pkg::SUBU,
					isa_pkg::SLT, isa_pkg::SLTU, isa_pkg::AND, isa_pkg::OR,
					isa_pkg::XOR, isa_pkg::NOR, isa_pkg::SLLV, isa_pkg::SRLV,
					isa_pkg::SRAV: begin
						read_rs = 1'b1;
						read_rt = 1'b1;
					end
					// shift amount comes from shamt
					isa_pkg::SLL, isa_pkg::SRL, isa_pkg::SRA: read_rt = 1'b1;
					isa_pkg::JR, isa_pkg::JALR, isa_pkg::MTHI, isa_pkg::MTLO: read_rs = 1'b1;
					default: ;
				endcase
			end
			isa_pkg::ADDI, isa_pkg::ADDIU, isa_pkg::SLTI, isa_pkg::SLTIU,
			isa_pkg::ANDI, isa_pkg::ORI, isa_pkg::XORI,
			isa_pkg::BLEZ, isa_pkg::BGTZ: read_rs = 1'b1;
			isa_pkg::BEQ, isa_pkg::BNE: begin
				read_rs = 1'b1;
				read_rt = 1'b1;
			end
			isa_pkg::REGIMM: begin
				case (instr.i.rt)
					isa_pkg::BLTZ, isa_pkg::BGEZ,
					isa_pkg::BLTZAL, isa_pkg::BGEZAL: read_rs = 1'b1;
					default: ;
				endcase
			end
			isa_pkg::SB, isa_pkg::SH, isa_pkg::SW: read_rt = 1'b1;
			isa_pkg::COP0: read_rt = (instr.r.rs == isa_pkg::MTC0);
			default: ;
		endcase
	end

endmodule

// ==== hw/branch_cond_dec.sv ====
`timescale 1ns/1ps

module branch_cond_dec (
	input  isa_pkg::instr_u        instr,
	output ctrl_pkg::branch_cond_e branch_cond
);

	always_comb begin
		case (instr.i.op)
			isa_pkg::BEQ: branch_cond = ctrl_pkg::EQ;
			isa_pkg::BNE: branch_cond = ctrl_pkg::NE;
			isa_pkg::BLEZ: branch_cond = ctrl_pkg::LEZ;
			isa_pkg::BGTZ: branch_cond = ctrl_pkg::GTZ;
			isa_pkg::REGIMM: begin
				// unknown rt still compares less than zero
				case (instr.i.rt)
					isa_pkg::BGEZ, isa_pkg::BGEZAL: branch_cond = ctrl_pkg::GEZ;
					default: branch_cond = ctrl_pkg::LTZ;
				endcase
			end
			default: branch_cond = ctrl_pkg::NONE;
		endcase
	end

endmodule

// ==== hw/decode_stage.sv ====
`timescale 1ns/1ps
`include "decode_cfg.svh"

module decode_stage (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [`DEC_WORD_W-1:0] instr,
	input  logic                   instr_valid,
	input  logic                   stall,
	output logic                   dec_valid,
	output logic                   regwrite,
	output logic                   regdst,
	output logic                   is_imm,
	output logic                   memtoreg,
	output logic                   mem_read,
	output logic                   mem_write,
	output logic                   sign_ex,
	output ctrl_pkg::alu_ctrl_e    alu_ctrl,
	output ctrl_pkg::branch_cond_e branch_cond,
	output logic                   read_rs,
	output logic                   read_rt,
	output logic                   cp0_write,
	output logic                   cp0_read,
	output logic                   is_mfc,
	output logic                   hilo_read,
	output logic                   mfhi,
	output logic                   mflo,
	output logic                   eret,
	output logic                   brk,
	output logic                   syscall,
	output logic                   ri,
	output logic                   only_one_inst
);

	isa_pkg::instr_u instr_q;
	logic valid_q;
	// raw decoder flags, same order as the output concatenation below
	logic [19:0] flags;
	ctrl_pkg::alu_op_e alu_op;
	ctrl_pkg::alu_ctrl_e alu_ctrl_raw;
	ctrl_pkg::branch_cond_e branch_cond_raw;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
		end else if (!stall) begin
			valid_q <= instr_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			instr_q <= instr;
		end
	end

	main_ctrl_dec u_main_ctrl_dec (
		.instr         (instr_q),
		.regwrite      (flags[19]),
		.regdst        (flags[18]),
		.is_imm        (flags[17]),
		.memtoreg      (flags[16]),
		.mem_read      (flags[15]),
		.mem_write     (flags[14]),
		.sign_ex       (flags[13]),
		.alu_op        (alu_op),
		.cp0_write     (flags[10]),
		.cp0_read      (flags[9]),
		.is_mfc        (flags[8]),
		.hilo_read     (flags[7]),
		.mfhi          (flags[6]),
		.mflo          (flags[5]),
		.eret          (flags[4]),
		.brk           (flags[3]),
		.syscall       (flags[2]),
		.ri            (flags[1]),
		.only_one_inst (flags[0])
	);

	alu_ctrl_dec u_alu_ctrl_dec (
		.alu_op   (alu_op),
		.instr    (instr_q),
		.alu_ctrl (alu_ctrl_raw)
	);

	operand_use_dec u_operand_use_dec (
		.instr   (instr_q),
		.read_rs (flags[12]),
		.read_rt (flags[11])
	);

	branch_cond_dec u_branch_cond_dec (
		.instr       (instr_q),
		.branch_cond (branch_cond_raw)
	);

	// a bubble shows no control at all
	assign dec_valid = valid_q;
	assign {regwrite, regdst, is_imm, memtoreg, mem_read, mem_write, sign_ex,
		read_rs, read_rt, cp0_write, cp0_read, is_mfc, hilo_read, mfhi, mflo,
		eret, brk, syscall, ri, only_one_inst} = flags & {20{valid_q}};
	assign alu_ctrl = valid_q ? alu_ctrl_raw : ctrl_pkg::NOP;
	assign branch_cond = valid_q ? branch_cond_raw : ctrl_pkg::NONE;

endmodule

// ==== sim/tb_decode_stage.sv ====
`timescale 1ns/1ps
`include "decode_cfg.svh"

module tb_decode_stage;

	localparam int RESET_CYCLES = 4;
	// one cycle per vector, about 90 vectors with twice that as slack
	localparam int VECTORS = 90;
	localparam int MAX_CYCLES = RESET_CYCLES + 2 * VECTORS + 20;
	localparam logic [`DEC_WORD_W-1:0] ERET_WORD = 32'h4200_0018;

	logic clk = 1'b0;
	logic rst_n;
	logic [`DEC_WORD_W-1:0] instr;
	logic instr_valid;
	logic stall;
	logic dec_valid;
	logic regwrite, regdst, is_imm, memtoreg, mem_read, mem_write, sign_ex;
	logic read_rs, read_rt, cp0_write, cp0_read, is_mfc, hilo_read, mfhi, mflo;
	logic eret, brk, syscall, ri, only_one_inst;
	ctrl_pkg::alu_ctrl_e alu_ctrl;
	ctrl_pkg::branch_cond_e branch_cond;
	logic [19:0] dut_flags;

	integer seed = 88;
	int error_count = 0;
	int check_count = 0;
	int cycle_count = 0;

	decode_stage dut_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.instr         (instr),
		.instr_valid   (instr_valid),
		.stall         (stall),
		.dec_valid     (dec_valid),
		.regwrite      (regwrite),
		.regdst        (regdst),
		.is_imm        (is_imm),
		.memtoreg      (memtoreg),
		.mem_read      (mem_read),
		.mem_write     (mem_write),
		.sign_ex       (sign_ex),
		.alu_ctrl      (alu_ctrl),
		.branch_cond   (branch_cond),
		.read_rs       (read_rs),
		.read_rt       (read_rt),
		.cp0_write     (cp0_write),
		.cp0_read      (cp0_read),
		.is_mfc        (is_mfc),
		.hilo_read     (hilo_read),
		.mfhi          (mfhi),
		.mflo          (mflo),
		.eret          (eret),
		.brk           (brk),
		.syscall       (syscall),
		.ri            (ri),
		.only_one_inst (only_one_inst)
	);

	assign dut_flags = {regwrite, regdst, is_imm, memtoreg, mem_read, mem_write, sign_ex,
		read_rs, read_rt, cp0_write, cp0_read, is_mfc, hilo_read, mfhi, mflo,
		eret, brk, syscall, ri, only_one_inst};

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
			$display("sim failed");
			$finish;
		end
	end

	// expected decode from the instruction groups
	function automatic void ref_decode(input isa_pkg::instr_u w, output logic [19:0] f,
		output ctrl_pkg::alu_ctrl_e a, output ctrl_pkg::branch_cond_e b);
		logic [5:0] op;
		logic [5:0] fn;
		logic [4:0] rs;
		logic [4:0] rt;
		logic is_r, alu3, shift_imm, rs_only, no_src, r_known, r_write;
		logic imm_alu, load, store, plain_br, regimm_ok, link_br, cop0, mtc0, mfc0, eret_w;
		logic rw, rd_sel, imm, sx, rrs, rrt, fhi, flo, bk, sc, rsv, one;
		op = w.r.op;
		fn = w.r.funct;
		rs = w.r.rs;
		rt = w.i.rt;
		is_r = (op == isa_pkg::R_TYPE);
		alu3 = is_r && (fn inside {isa_pkg::ADD, isa_pkg::ADDU, isa_pkg::SUB, isa_pkg::SUBU,
			isa_pkg::SLT, isa_pkg::SLTU, isa_pkg::AND, isa_pkg::OR, isa_pkg::XOR,
			isa_pkg::NOR, isa_pkg::SLLV, isa_pkg::SRLV, isa_pkg::SRAV});
		shift_imm = is_r && (fn inside {isa_pkg::SLL, isa_pkg::SRL, isa_pkg::SRA});
		rs_only = is_r && (fn inside {isa_pkg::JR, isa_pkg::JALR, isa_pkg::MTHI, isa_pkg::MTLO});
		no_src = is_r && (fn inside {isa_pkg::MFHI, isa_pkg::MFLO, isa_pkg::SYSCALL,
			isa_pkg::BREAK});
		r_known = alu3 | shift_imm | rs_only | no_src;
		r_write = is_r && (fn inside {isa_pkg::JALR, isa_pkg::MFHI, isa_pkg::MFLO});
		imm_alu = op inside {isa_pkg::ADDI, isa_pkg::ADDIU, isa_pkg::SLTI, isa_pkg::SLTIU,
			isa_pkg::ANDI, isa_pkg::ORI, isa_pkg::XORI, isa_pkg::LUI};
		load = op inside {isa_pkg::LW, isa_pkg::LB, isa_pkg::LBU, isa_pkg::LH, isa_pkg::LHU};
		store = op inside {isa_pkg::SW, isa_pkg::SB, isa_pkg::SH};
		plain_br = op inside {isa_pkg::BEQ, isa_pkg::BNE, isa_pkg::BLEZ, isa_pkg::BGTZ,
			isa_pkg::J};
		regimm_ok = (op == isa_pkg::REGIMM) && (rt inside {isa_pkg::BLTZ, isa_pkg::BGEZ,
			isa_pkg::BLTZAL, isa_pkg::BGEZAL});
		link_br = (op == isa_pkg::REGIMM) && (rt inside {isa_pkg::BLTZAL, isa_pkg::BGEZAL});
		cop0 = (op == isa_pkg::COP0);
		mtc0 = cop0 && (rs == isa_pkg::MTC0);
		mfc0 = cop0 && (rs == isa_pkg::MFC0);
		eret_w = (w == ERET_WORD);
		rsv = !(r_known | imm_alu | load | store | plain_br | (op == isa_pkg::JAL) |
			regimm_ok | mtc0 | mfc0 | eret_w);
		// unknown R-type still writes back
		rw = alu3 | shift_imm | r_write | (is_r && !r_known) | imm_alu | load |
			(op == isa_pkg::JAL) | link_br | mfc0;
		rd_sel = alu3 | shift_imm | r_write | (op == isa_pkg::JAL) | link_br;
		imm = imm_alu | load | store | mfc0;
		sx = !(op inside {isa_pkg::ANDI, isa_pkg::ORI, isa_pkg::XORI, isa_pkg::LUI});
		rrs = alu3 | rs_only | (imm_alu && op != isa_pkg::LUI) | regimm_ok |
			(op inside {isa_pkg::BLEZ, isa_pkg::BGTZ, isa_pkg::BEQ, isa_pkg::BNE});
		rrt = alu3 | shift_imm | (op inside {isa_pkg::BEQ, isa_pkg::BNE}) | store | mtc0;
		fhi = is_r && (fn == isa_pkg::MFHI);
		flo = is_r && (fn == isa_pkg::MFLO);
		bk = is_r && (fn == isa_pkg::BREAK);
		sc = is_r && (fn == isa_pkg::SYSCALL);
		one = load | store | cop0;
		f = {rw, rd_sel, imm, load, load, store, sx, rrs, rrt, mtc0, mfc0, mfc0,
			fhi | flo, fhi, flo, eret_w, bk, sc, rsv, one};

		a = ctrl_pkg::NOP;
		if (alu3 | shift_imm) begin
			case (fn)
				isa_pkg::ADD: a = ctrl_pkg::ADD;
				isa_pkg::ADDU: a = ctrl_pkg::ADDU;
				isa_pkg::SUB: a = ctrl_pkg::SUB;
				isa_pkg::SUBU: a = ctrl_pkg::SUBU;
				isa_pkg::SLT: a = ctrl_pkg::SLT;
				isa_pkg::SLTU: a = ctrl_pkg::SLTU;
				isa_pkg::AND: a = ctrl_pkg::AND;
				isa_pkg::OR: a = ctrl_pkg::OR;
				isa_pkg::XOR: a = ctrl_pkg::XOR;
				isa_pkg::NOR: a = ctrl_pkg::NOR;
				isa_pkg::SLL: a = ctrl_pkg::SLL;
				isa_pkg::SRL: a = ctrl_pkg::SRL;
				isa_pkg::SRA: a = ctrl_pkg::SRA;
				isa_pkg::SLLV: a = ctrl_pkg::SLLV;
				isa_pkg::SRLV: a = ctrl_pkg::SRLV;
				default: a = ctrl_pkg::SRAV;
			endcase
		end else if (imm_alu) begin
			case (op)
				isa_pkg::ADDI: a = ctrl_pkg::ADD;
				isa_pkg::ADDIU: a = ctrl_pkg::ADDU;
				isa_pkg::SLTI: a = ctrl_pkg::SLT;
				isa_pkg::SLTIU: a = ctrl_pkg::SLTU;
				isa_pkg::ANDI: a = ctrl_pkg::AND;
				isa_pkg::ORI: a = ctrl_pkg::OR;
				isa_pkg::XORI: a = ctrl_pkg::XOR;
				default: a = ctrl_pkg::LUI;
			endcase
		end else if (load | store) begin
			a = ctrl_pkg::ADDU;
		end else if (mtc0) begin
			a = ctrl_pkg::MTC0;
		end else if (mfc0) begin
			a = ctrl_pkg::MFC0;
		end

		case (op)
			isa_pkg::BEQ: b = ctrl_pkg::EQ;
			isa_pkg::BNE: b = ctrl_pkg::NE;
			isa_pkg::BLEZ: b = ctrl_pkg::LEZ;
			isa_pkg::BGTZ: b = ctrl_pkg::GTZ;
			isa_pkg::REGIMM: begin
				b = (rt inside {isa_pkg::BGEZ, isa_pkg::BGEZAL}) ? ctrl_pkg::GEZ : ctrl_pkg::LTZ;
			end
			default: b = ctrl_pkg::NONE;
		endcase
	endfunction

	function automatic logic [4:0] rand_reg();
		integer r;
		r = $random(seed);
		return r[4:0];
	endfunction

	function automatic isa_pkg::instr_u r_word(input logic [5:0] op, input logic [4:0] rt,
		input logic [5:0] fn);
		isa_pkg::instr_u w;
		w.r.op = isa_pkg::opcode_e'(op);
		w.r.rs = rand_reg();
		w.r.rt = rt;
		w.r.rd = rand_reg();
		w.r.shamt = rand_reg();
		w.r.funct = isa_pkg::funct_e'(fn);
		return w;
	endfunction

	function automatic isa_pkg::instr_u i_word(input logic [5:0] op, input logic [4:0] rt);
		isa_pkg::instr_u w;
		integer r;
		r = $random(seed);
		w.i.op = isa_pkg::opcode_e'(op);
		w.i.rs = rand_reg();
		w.i.rt = rt;
		w.i.imm = r[`DEC_IMM_W-1:0];
		return w;
	endfunction

	function automatic isa_pkg::instr_u j_word(input logic [5:0] op);
		isa_pkg::instr_u w;
		integer r;
		r = $random(seed);
		w.j.op = isa_pkg::opcode_e'(op);
		w.j.target = r[`DEC_WORD_W-`DEC_OP_W-1:0];
		return w;
	endfunction

	task automatic check_bit(input logic got, input logic exp, input string what);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("** Error @ %0t ns: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_flags(input logic [19:0] got, input logic [19:0] exp,
		input string what);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("** Error @ %0t ns: %s flags got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_alu(input ctrl_pkg::alu_ctrl_e got, input ctrl_pkg::alu_ctrl_e exp,
		input string what);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("** Error @ %0t ns: %s alu_ctrl got %s expected %s", $time, what,
				got.name(), exp.name());
		end
	endtask

	task automatic check_branch(input ctrl_pkg::branch_cond_e got,
		input ctrl_pkg::branch_cond_e exp, input string what);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("** Error @ %0t ns: %s branch_cond got %s expected %s", $time, what,
				got.name(), exp.name());
		end
	endtask

	task automatic check_decode(input isa_pkg::instr_u w, input string what);
		logic [19:0] exp_f;
		ctrl_pkg::alu_ctrl_e exp_a;
		ctrl_pkg::branch_cond_e exp_b;
		ref_decode(w, exp_f, exp_a, exp_b);
		check_bit(dec_valid, 1'b1, {what, " dec_valid"});
		check_flags(dut_flags, exp_f, what);
		check_alu(alu_ctrl, exp_a, what);
		check_branch(branch_cond, exp_b, what);
	endtask

	task automatic check_bubble(input string what);
		check_bit(dec_valid, 1'b0, {what, " dec_valid"});
		check_flags(dut_flags, '0, what);
		check_alu(alu_ctrl, ctrl_pkg::NOP, what);
		check_branch(branch_cond, ctrl_pkg::NONE, what);
	endtask

	// starts and ends on a falling edge
	task automatic run_vector(input isa_pkg::instr_u w, input string what);
		string tag;
		tag = $sformatf("%s (%h)", what, w);
		instr = w;
		instr_valid = 1'b1;
		stall = 1'b0;
		@(negedge clk);
		check_decode(w, tag);
	endtask

	task automatic test_alu_ops();
		isa_pkg::funct_e fns [20];
		isa_pkg::opcode_e ops [8];
		fns = '{isa_pkg::ADD, isa_pkg::ADDU, isa_pkg::SUB, isa_pkg::SUBU, isa_pkg::SLT,
			isa_pkg::SLTU, isa_pkg::AND, isa_pkg::OR, isa_pkg::XOR, isa_pkg::NOR,
			isa_pkg::SLL, isa_pkg::SRL, isa_pkg::SRA, isa_pkg::SLLV, isa_pkg::SRLV,
			isa_pkg::SRAV, isa_pkg::JR, isa_pkg::JALR, isa_pkg::MTHI, isa_pkg::MTLO};
		ops = '{isa_pkg::ADDI, isa_pkg::ADDIU, isa_pkg::SLTI, isa_pkg::SLTIU,
			isa_pkg::ANDI, isa_pkg::ORI, isa_pkg::XORI, isa_pkg::LUI};
		for (int k = 0; k < 20; k++) begin
			run_vector(r_word(isa_pkg::R_TYPE, rand_reg(), fns[k]), fns[k].name());
		end
		for (int k = 0; k < 8; k++) begin
			run_vector(i_word(ops[k], rand_reg()), ops[k].name());
		end
	endtask

	task automatic test_mem_branch();
		isa_pkg::opcode_e ops [12];
		isa_pkg::regimm_e rts [4];
		ops = '{isa_pkg::LW, isa_pkg::LB, isa_pkg::LBU, isa_pkg::LH, isa_pkg::LHU,
			isa_pkg::SW, isa_pkg::SB, isa_pkg::SH, isa_pkg::BEQ, isa_pkg::BNE,
			isa_pkg::BLEZ, isa_pkg::BGTZ};
		rts = '{isa_pkg::BLTZ, isa_pkg::BGEZ, isa_pkg::BLTZAL, isa_pkg::BGEZAL};
		for (int k = 0; k < 12; k++) begin
			run_vector(i_word(ops[k], rand_reg()), ops[k].name());
		end
		for (int k = 0; k < 4; k++) begin
			run_vector(i_word(isa_pkg::REGIMM, rts[k]), rts[k].name());
		end
		run_vector(j_word(isa_pkg::J), "J");
		run_vector(j_word(isa_pkg::JAL), "JAL");
	endtask

	task automatic test_cop0_system();
		// rs carries the move direction, rt and rd stay random
		run_vector(r_word(isa_pkg::COP0, rand_reg(), 6'h00) & 32'hfc1f_f800 |
			{6'b0, isa_pkg::MTC0, 21'b0}, "MTC0");
		run_vector(r_word(isa_pkg::COP0, rand_reg(), 6'h00) & 32'hfc1f_f800 |
			{6'b0, isa_pkg::MFC0, 21'b0}, "MFC0");
		run_vector(ERET_WORD, "ERET");
		run_vector(r_word(isa_pkg::R_TYPE, rand_reg(), isa_pkg::SYSCALL), "SYSCALL");
		run_vector(r_word(isa_pkg::R_TYPE, rand_reg(), isa_pkg::BREAK), "BREAK");
		run_vector(r_word(isa_pkg::R_TYPE, rand_reg(), isa_pkg::MFHI), "MFHI");
		run_vector(r_word(isa_pkg::R_TYPE, rand_reg(), isa_pkg::MFLO), "MFLO");
		// cop0 rs outside mfc0, mtc0 and eret
		run_vector(ERET_WORD & 32'hfc1f_ffff | 32'h0020_0000, "COP0 rs=1");
		check_bit(ri, 1'b1, "COP0 rs=1 ri");
		run_vector(ERET_WORD | 32'h0000_0001, "ERET bad funct");
		check_bit(ri, 1'b1, "ERET bad funct ri");
	endtask

	task automatic check_reserved(input logic [5:0] op, input logic [4:0] rt,
		input logic [5:0] fn, input string what);
		run_vector(r_word(op, rt, fn), what);
		check_bit(ri, 1'b1, {what, " ri"});
		check_alu(alu_ctrl, ctrl_pkg::NOP, what);
	endtask

	task automatic test_reserved();
		check_reserved(6'b011100, rand_reg(), 6'b000010, "SPECIAL2 MUL");
		check_reserved(6'b011100, rand_reg(), 6'b100000, "SPECIAL2 CLZ");
		check_reserved(6'b011111, rand_reg(), 6'b100000, "SPECIAL3 BSHFL");
		check_reserved(6'b000000, rand_reg(), 6'b110100, "TEQ");
		check_reserved(6'b000000, rand_reg(), 6'b110000, "TGE");
		check_reserved(6'b000001, 5'b01100, 6'b000000, "TEQI");
		check_reserved(6'b000000, rand_reg(), 6'b001011, "MOVN");
		check_reserved(6'b110000, rand_reg(), 6'b000000, "LL");
		check_reserved(6'b100010, rand_reg(), 6'b000000, "LWL");
		check_reserved(6'b100110, rand_reg(), 6'b000000, "LWR");
		check_reserved(6'b101010, rand_reg(), 6'b000000, "SWL");
		check_reserved(6'b111111, rand_reg(), 6'b111111, "unknown op");
	endtask

	task automatic test_stall_valid();
		isa_pkg::instr_u wa;
		isa_pkg::instr_u wb;
		wa = i_word(isa_pkg::ADDI, rand_reg());
		wb = r_word(isa_pkg::R_TYPE, rand_reg(), isa_pkg::SUB);
		run_vector(wa, "before stall");
		// held word must survive a new input
		instr = wb;
		stall = 1'b1;
		repeat (2) begin
			@(negedge clk);
			check_decode(wa, "under stall");
		end
		run_vector(wb, "after stall");
		instr = i_word(isa_pkg::LW, rand_reg());
		instr_valid = 1'b0;
		@(negedge clk);
		check_bubble("bubble");
	endtask

	initial begin
		rst_n = 1'b0;
		// a valid word offered during reset must not get through
		instr = i_word(isa_pkg::ADDI, rand_reg());
		instr_valid = 1'b1;
		stall = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk);
		check_bubble("in reset");
		instr_valid = 1'b0;
		rst_n = 1'b1;
		@(negedge clk);
		check_bubble("after reset");
		test_alu_ops();
		test_mem_branch();
		test_cop0_system();
		test_reserved();
		test_stall_valid();
		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+include
hw/isa_pkg.sv
hw/ctrl_pkg.sv
hw/main_ctrl_dec.sv
hw/alu_ctrl_dec.sv
hw/operand_use_dec.sv
hw/branch_cond_dec.sv
hw/decode_stage.sv
sim/tb_decode_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f all.f \
	--top-module tb_decode_stage -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_decode_stage)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "sim passed"; then
	exit 0
fi
exit 1
